// ==== Bender.yml ====
package:
  name: qracc

sources:
  - src/qracc_pkg.sv
  - src/qracc_csr.sv
  - src/qracc_ctrl.sv
  - src/qracc_window_gen.sv
  - src/qracc_top.sv
  - target: test
    files:
      - testbench/tb_qracc_top.sv

// ==== files.f ====
src/qracc_pkg.sv
src/qracc_csr.sv
src/qracc_ctrl.sv
src/qracc_window_gen.sv
src/qracc_top.sv
testbench/tb_qracc_top.sv

// ==== src/qracc_csr.sv ====
// Config writes stall while busy; MAIN is status on read, trigger/clear strobes on write
`timescale 1ns/1ps

module qracc_csr (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               bus_valid_i,
    input  logic [qracc_pkg::BUS_ADDR_W-1:0]   bus_addr_i,
    input  logic                               bus_wen_i,
    input  logic [qracc_pkg::BUS_DATA_W-1:0]   bus_wdata_i,
    output logic                               bus_ready_o,
    output logic [qracc_pkg::BUS_DATA_W-1:0]   bus_rdata_o,
    output logic                               trig_run_o,
    output logic                               trig_clear_o,
    input  logic                               busy_i,
    input  qracc_pkg::qracc_state_t            state_i,
    input  logic [qracc_pkg::JOB_CNT_W-1:0]    job_count_i,
    output logic [qracc_pkg::DIM_W-1:0]        out_dimx_o,
    output logic [qracc_pkg::DIM_W-1:0]        out_dimy_o,
    output logic [qracc_pkg::SMALL_W-1:0]      stride_x_o,
    output logic [qracc_pkg::SMALL_W-1:0]      stride_y_o,
    output logic [qracc_pkg::DIM_W-1:0]        offset_x_o,
    output logic [qracc_pkg::DIM_W-1:0]        offset_y_o
);
    import qracc_pkg::*;

    // CONFIG..OFFSETS storage; MAIN has no storage of its own
    logic [BUS_DATA_W-1:0] cfg_regs_q [CSR_REG_CONFIG:CSR_REG_OFFSETS];

    csr_names_t            csr_idx;
    logic                  in_window;
    logic                  cfg_hit;
    logic                  accept;
    logic                  main_wr;
    logic [BUS_DATA_W-1:0] main_rd;

    // Address decode
    assign in_window = (bus_addr_i & CSR_BASE_MASK) == CSR_BASE_ADDR;
    assign csr_idx   = csr_names_t'(bus_addr_i[3:0]);
    assign cfg_hit   = in_window && (csr_idx >= CSR_REG_CONFIG) && (csr_idx <= CSR_REG_OFFSETS);

    // Only config accesses wait for the job to finish
    assign bus_ready_o = !(busy_i && cfg_hit);
    assign accept      = bus_valid_i && bus_ready_o;
    assign main_wr     = accept && bus_wen_i && in_window && (csr_idx == CSR_REG_MAIN);

    // Strobes in the accept cycle itself
    assign trig_run_o   = main_wr &&
        (qracc_trigger_t'(bus_wdata_i[MAIN_TRIG_LSB +: TRIGGER_W]) == TRIGGER_RUN);
    assign trig_clear_o = main_wr && bus_wdata_i[MAIN_CLEAR_BIT];

    // MAIN status word
    always_comb begin
        main_rd = '0;
        main_rd[MAIN_BUSY_BIT] = busy_i;
        main_rd[MAIN_STATE_LSB +: STATE_W] = state_i;
        main_rd[MAIN_COUNT_LSB +: JOB_CNT_W] = job_count_i;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = CSR_REG_CONFIG; i <= CSR_REG_OFFSETS; i++) begin
                cfg_regs_q[i] <= '0;
            end
        end else if (accept && bus_wen_i && cfg_hit) begin
            cfg_regs_q[csr_idx] <= bus_wdata_i;
        end
    end

    // Read data held until the next accepted read
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bus_rdata_o <= '0;
        end else if (accept && !bus_wen_i) begin
            if (!in_window) begin
                bus_rdata_o <= '0; // Outside the window
            end else if (csr_idx == CSR_REG_MAIN) begin
                bus_rdata_o <= main_rd;
            end else if (cfg_hit) begin
                bus_rdata_o <= cfg_regs_q[csr_idx];
            end else begin
                bus_rdata_o <= '0; // Unmapped index
            end
        end
    end

    // Filter size, bit counts, ADC shift, ifmap dims and channels stay readback only
    assign stride_x_o = cfg_regs_q[CSR_REG_CONFIG][CFG_STRIDE_X_LSB +: SMALL_W];
    assign stride_y_o = cfg_regs_q[CSR_REG_CONFIG][CFG_STRIDE_Y_LSB +: SMALL_W];
    assign out_dimx_o = cfg_regs_q[CSR_REG_OFMAP_DIMS][FIELD_X_LSB +: DIM_W];
    assign out_dimy_o = cfg_regs_q[CSR_REG_OFMAP_DIMS][FIELD_Y_LSB +: DIM_W];
    assign offset_x_o = cfg_regs_q[CSR_REG_OFFSETS][FIELD_X_LSB +: DIM_W];
    assign offset_y_o = cfg_regs_q[CSR_REG_OFFSETS][FIELD_Y_LSB +: DIM_W];

    // The configuration seen by the scan must not move under a running job
    a_no_cfg_write_busy: assert property (
        @(posedge clk) disable iff (!nrst)
        busy_i |=> $stable({cfg_regs_q[CSR_REG_CONFIG], cfg_regs_q[CSR_REG_IFMAP_DIMS],
            cfg_regs_q[CSR_REG_OFMAP_DIMS], cfg_regs_q[CSR_REG_CHANNELS],
            cfg_regs_q[CSR_REG_OFFSETS]})
    );

endmodule

// ==== src/qracc_ctrl.sv ====
// Job sequencer; RUN while busy is dropped, clear beats RUN, zero-size jobs skip the scan
`timescale 1ns/1ps

module qracc_ctrl (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            trig_run_i,
    input  logic                            trig_clear_i,
    input  logic                            scan_done_i,
    input  logic [qracc_pkg::DIM_W-1:0]     out_dimx_i,
    input  logic [qracc_pkg::DIM_W-1:0]     out_dimy_i,
    output logic                            busy_o,
    output qracc_pkg::qracc_state_t         state_o,
    output logic [qracc_pkg::JOB_CNT_W-1:0] job_count_o,
    output logic                            scan_start_o,
    output logic                            scan_abort_o
);
    import qracc_pkg::*;

    qracc_state_t state_d;
    logic         busy_d;
    logic         zero_size;
    logic         run_accept;
    logic         finish;
    logic         count_en;

    // Config is frozen while busy, so checking dims in RUN is safe
    assign zero_size  = (out_dimx_i == '0) || (out_dimy_i == '0);
    assign run_accept = trig_run_i && !trig_clear_i && !busy_o;
    assign finish     = (state_o == ST_RUN) && (scan_done_i || zero_size);
    assign count_en   = finish && !trig_clear_i; // Aborted jobs don't count

    assign scan_start_o = run_accept && !zero_size; // Lands with busy on the same edge
    assign scan_abort_o = trig_clear_i;

    always_comb begin
        state_d = state_o;
        busy_d  = busy_o;
        if (trig_clear_i) begin
            state_d = ST_IDLE;
            busy_d  = 1'b0;
        end else if (run_accept) begin
            state_d = ST_RUN; // Also from DONE, back to back
            busy_d  = 1'b1;
        end else if (finish) begin
            state_d = ST_DONE;
            busy_d  = 1'b0;
        end else if (state_o == ST_DONE) begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_o     <= ST_IDLE;
            busy_o      <= 1'b0;
            job_count_o <= '0;
        end else begin
            state_o <= state_d;
            busy_o  <= busy_d;
            if (count_en) begin
                job_count_o <= job_count_o + 1'b1; // Wraps
            end
        end
    end

    // Busy flag and state register must agree
    a_busy_not_idle: assert property (
        @(posedge clk) disable iff (!nrst)
        busy_o |-> (state_o != ST_IDLE)
    );

endmodule

// ==== src/qracc_pkg.sv ====
// Register map, field positions and enums; the bus is single-cycle valid/ready, no AXI4-Lite
package qracc_pkg;

    // Host bus
    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;

    // Register window, low nibble picks the register
    localparam logic [BUS_ADDR_W-1:0] CSR_BASE_ADDR = 32'h0000_0010;
    localparam logic [BUS_ADDR_W-1:0] CSR_BASE_MASK = 32'hFFFF_FFF0;

    typedef enum logic [3:0] {
        CSR_REG_MAIN       = 4'd0,
        CSR_REG_CONFIG     = 4'd1,
        CSR_REG_IFMAP_DIMS = 4'd2,
        CSR_REG_OFMAP_DIMS = 4'd3,
        CSR_REG_CHANNELS   = 4'd4,
        CSR_REG_OFFSETS    = 4'd5
    } csr_names_t;

    // Field widths
    localparam int DIM_W     = 16; // Dimensions, channels, offsets
    localparam int SMALL_W   = 4;  // Stride, filter size, bit counts, ADC shift
    localparam int JOB_CNT_W = 8;
    localparam int TRIGGER_W = 3;
    localparam int STATE_W   = 4;

    // Host commands carried in MAIN[2:0]
    typedef enum logic [TRIGGER_W-1:0] {
        TRIGGER_IDLE = 3'd0,
        TRIGGER_RUN  = 3'd1
    } qracc_trigger_t;

    // Controller state, visible in MAIN readback
    typedef enum logic [STATE_W-1:0] {
        ST_IDLE = 4'd0,
        ST_RUN  = 4'd1,
        ST_DONE = 4'd2 // Single cycle after the last item
    } qracc_state_t;

    // MAIN write side
    localparam int MAIN_TRIG_LSB  = 0;
    localparam int MAIN_CLEAR_BIT = 3;

    // MAIN read side, all other bits zero
    localparam int MAIN_COUNT_LSB = 0;
    localparam int MAIN_STATE_LSB = 20;
    localparam int MAIN_BUSY_BIT  = 27;

    // CONFIG register, only the strides leave the CSR block
    localparam int CFG_STRIDE_X_LSB = 16;
    localparam int CFG_STRIDE_Y_LSB = 20;

    // Two-field registers (dims, offsets) split into halves
    localparam int FIELD_X_LSB = 0;
    localparam int FIELD_Y_LSB = 16;

endpackage

// ==== src/qracc_top.sv ====
// Control and scan front end only; the compute array consumes the window stream outside
`timescale 1ns/1ps

module qracc_top (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             bus_valid_i,
    input  logic [qracc_pkg::BUS_ADDR_W-1:0] bus_addr_i,
    input  logic                             bus_wen_i,
    input  logic [qracc_pkg::BUS_DATA_W-1:0] bus_wdata_i,
    output logic                             bus_ready_o,
    output logic [qracc_pkg::BUS_DATA_W-1:0] bus_rdata_o,
    output logic                             win_valid_o,
    output logic [qracc_pkg::DIM_W-1:0]      win_x_o,
    output logic [qracc_pkg::DIM_W-1:0]      win_y_o,
    output logic                             win_last_o,
    input  logic                             win_ready_i,
    output logic                             busy_o
);
    import qracc_pkg::*;

    logic                 trig_run;
    logic                 trig_clear;
    qracc_state_t         state;
    logic [JOB_CNT_W-1:0] job_count;
    logic [DIM_W-1:0]     out_dimx;
    logic [DIM_W-1:0]     out_dimy;
    logic [SMALL_W-1:0]   stride_x;
    logic [SMALL_W-1:0]   stride_y;
    logic [DIM_W-1:0]     offset_x;
    logic [DIM_W-1:0]     offset_y;
    logic                 scan_start;
    logic                 scan_abort;
    logic                 scan_done;

    qracc_csr u_csr (
        .clk(clk), .nrst(nrst),
        .bus_valid_i(bus_valid_i), .bus_addr_i(bus_addr_i),
        .bus_wen_i(bus_wen_i), .bus_wdata_i(bus_wdata_i),
        .bus_ready_o(bus_ready_o), .bus_rdata_o(bus_rdata_o),
        .trig_run_o(trig_run), .trig_clear_o(trig_clear),
        .busy_i(busy_o), .state_i(state), .job_count_i(job_count),
        .out_dimx_o(out_dimx), .out_dimy_o(out_dimy),
        .stride_x_o(stride_x), .stride_y_o(stride_y),
        .offset_x_o(offset_x), .offset_y_o(offset_y)
    );

    qracc_ctrl u_ctrl (
        .clk(clk), .nrst(nrst),
        .trig_run_i(trig_run), .trig_clear_i(trig_clear), .scan_done_i(scan_done),
        .out_dimx_i(out_dimx), .out_dimy_i(out_dimy),
        .busy_o(busy_o), .state_o(state), .job_count_o(job_count),
        .scan_start_o(scan_start), .scan_abort_o(scan_abort)
    );

    qracc_window_gen u_window_gen (
        .clk(clk), .nrst(nrst),
        .scan_start_i(scan_start), .scan_abort_i(scan_abort),
        .out_dimx_i(out_dimx), .out_dimy_i(out_dimy),
        .stride_x_i(stride_x), .stride_y_i(stride_y),
        .offset_x_i(offset_x), .offset_y_i(offset_y),
        .win_ready_i(win_ready_i), .scan_done_o(scan_done),
        .win_valid_o(win_valid_o), .win_x_o(win_x_o), .win_y_o(win_y_o),
        .win_last_o(win_last_o)
    );

endmodule

// ==== src/qracc_window_gen.sv ====
// Raster scan of output pixels, origins wrap at 16 bits; start is ignored unless idle
`timescale 1ns/1ps

module qracc_window_gen (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          scan_start_i,
    input  logic                          scan_abort_i,
    input  logic [qracc_pkg::DIM_W-1:0]   out_dimx_i,
    input  logic [qracc_pkg::DIM_W-1:0]   out_dimy_i,
    input  logic [qracc_pkg::SMALL_W-1:0] stride_x_i,
    input  logic [qracc_pkg::SMALL_W-1:0] stride_y_i,
    input  logic [qracc_pkg::DIM_W-1:0]   offset_x_i,
    input  logic [qracc_pkg::DIM_W-1:0]   offset_y_i,
    input  logic                          win_ready_i,
    output logic                          scan_done_o,
    output logic                          win_valid_o,
    output logic [qracc_pkg::DIM_W-1:0]   win_x_o,
    output logic [qracc_pkg::DIM_W-1:0]   win_y_o,
    output logic                          win_last_o
);
    import qracc_pkg::*;

    logic [DIM_W-1:0] ox_q;
    logic [DIM_W-1:0] oy_q;
    logic             x_end;
    logic             y_end;
    logic             fire;

    assign x_end = (ox_q == out_dimx_i - 1'b1);
    assign y_end = (oy_q == out_dimy_i - 1'b1);
    assign fire  = win_valid_o && win_ready_i;

    assign win_last_o  = win_valid_o && x_end && y_end;
    assign scan_done_o = fire && x_end && y_end;

    // Counters and valid
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            win_valid_o <= 1'b0;
            ox_q        <= '0;
            oy_q        <= '0;
        end else if (scan_abort_i) begin
            win_valid_o <= 1'b0;
        end else if (scan_start_i && !win_valid_o) begin
            win_valid_o <= 1'b1;
            ox_q        <= '0;
            oy_q        <= '0;
        end else if (fire) begin
            if (x_end && y_end) begin
                win_valid_o <= 1'b0;
            end else if (x_end) begin
                ox_q <= '0;
                oy_q <= oy_q + 1'b1;
            end else begin
                ox_q <= ox_q + 1'b1;
            end
        end
    end

    // Origins built by adding strides, no multiplier
    always_ff @(posedge clk) begin
        if (scan_start_i && !win_valid_o) begin
            win_x_o <= offset_x_i;
            win_y_o <= offset_y_i;
        end else if (fire && !y_end && x_end) begin
            win_x_o <= offset_x_i; // New row
            win_y_o <= win_y_o + DIM_W'(stride_y_i);
        end else if (fire && !x_end) begin
            win_x_o <= win_x_o + DIM_W'(stride_x_i);
        end
    end

    // Stalled item holds until taken or aborted
    a_stall_stable: assert property (
        @(posedge clk) disable iff (!nrst)
        (win_valid_o && !win_ready_i && !scan_abort_i) |=>
            (win_valid_o && $stable(win_x_o) && $stable(win_y_o) && $stable(win_last_o))
    );

endmodule

// ==== testbench/tb_qracc_top.sv ====
// Checks rely on concurrent SVA and a timed simulator; one bus transfer at a time, seed fixed at 99
`timescale 1ns/1ps

module tb_qracc_top;
    import qracc_pkg::*;

    localparam int MAX_CYCLES = 2000; // Three jobs of at most 48 items with stalls, plus bus traffic

    logic        clk = 1'b0;
    logic        nrst;
    logic        bus_valid_i;
    logic [31:0] bus_addr_i;
    logic        bus_wen_i;
    logic [31:0] bus_wdata_i;
    logic        bus_ready_o;
    logic [31:0] bus_rdata_o;
    logic        win_valid_o;
    logic [15:0] win_x_o;
    logic [15:0] win_y_o;
    logic        win_last_o;
    logic        win_ready_i;
    logic        busy_o;

    // Configuration as the host wrote it
    logic [15:0] cfg_dimx = '0;
    logic [15:0] cfg_dimy = '0;
    logic [3:0]  cfg_sx = '0;
    logic [3:0]  cfg_sy = '0;
    logic [15:0] cfg_offx = '0;
    logic [15:0] cfg_offy = '0;

    logic [15:0] exp_ox;
    logic [15:0] exp_oy;
    logic [15:0] exp_x;
    logic [15:0] exp_y;
    logic        exp_last;
    logic [7:0]  exp_count = '0;
    logic        main_acc;
    logic        run_acc;
    logic        clr_acc;
    int          items_seen;
    int          cycles = 0;
    int          value_errors = 0;
    int          event_errors = 0;
    integer      seed = 99;

    qracc_top uut (.*);

    always #5 clk = ~clk;

    // Host-side view of MAIN commands
    assign main_acc = bus_valid_i && bus_ready_o && bus_wen_i && (bus_addr_i == CSR_BASE_ADDR);
    assign clr_acc  = main_acc && bus_wdata_i[3];
    assign run_acc  = main_acc && !bus_wdata_i[3] && (bus_wdata_i[2:0] == 3'd1) && !busy_o;

    // Reference scan with origin = o * stride + offset
    always @(posedge clk or negedge nrst) begin
        if (!nrst || run_acc) begin
            exp_ox     <= '0;
            exp_oy     <= '0;
            items_seen <= 0;
        end else if (win_valid_o && win_ready_i) begin
            items_seen <= items_seen + 1;
            if (exp_ox == cfg_dimx - 16'd1) begin
                exp_ox <= '0;
                exp_oy <= exp_oy + 16'd1;
            end else begin
                exp_ox <= exp_ox + 16'd1;
            end
        end
    end
    assign exp_x    = exp_ox * cfg_sx + cfg_offx;
    assign exp_y    = exp_oy * cfg_sy + cfg_offy;
    assign exp_last = (exp_ox == cfg_dimx - 16'd1) && (exp_oy == cfg_dimy - 16'd1);

    always @(posedge clk) begin
        #1;
        win_ready_i = ($random(seed) % 2) != 0; // Random back-pressure
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        value_errors++;
        $display("ERROR t=%0t %s: expected 0x%0h, got 0x%0h", $time, name, exp, got);
    endtask

    task automatic event_error(input string what);
        event_errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    // Stream and timing checks
    a_win_x: assert property (@(posedge clk) disable iff (!nrst)
        (win_valid_o && win_ready_i) |-> (win_x_o == exp_x))
        else value_error("win_x_o", $sampled(exp_x), $sampled(win_x_o));
    a_win_y: assert property (@(posedge clk) disable iff (!nrst)
        (win_valid_o && win_ready_i) |-> (win_y_o == exp_y))
        else value_error("win_y_o", $sampled(exp_y), $sampled(win_y_o));
    a_win_last: assert property (@(posedge clk) disable iff (!nrst)
        win_valid_o |-> (win_last_o == exp_last))
        else value_error("win_last_o", $sampled(exp_last), $sampled(win_last_o));
    a_stall: assert property (@(posedge clk) disable iff (!nrst)
        (win_valid_o && !win_ready_i && !clr_acc) |=>
            (win_valid_o && $stable(win_x_o) && $stable(win_y_o) && $stable(win_last_o)))
        else event_error("window item changed or vanished while stalled");
    a_busy_rise: assert property (@(posedge clk) disable iff (!nrst) run_acc |=> busy_o)
        else value_error("busy_o", 1, 0);
    a_valid_rise: assert property (@(posedge clk) disable iff (!nrst)
        (run_acc && cfg_dimx != 0 && cfg_dimy != 0) |=> win_valid_o)
        else value_error("win_valid_o", 1, 0);
    a_job_end: assert property (@(posedge clk) disable iff (!nrst)
        (win_valid_o && win_ready_i && win_last_o) |=> (!busy_o && !win_valid_o))
        else event_error("busy_o or win_valid_o still high after the last item");
    a_clear: assert property (@(posedge clk) disable iff (!nrst)
        clr_acc |=> (!busy_o && !win_valid_o))
        else event_error("clear did not stop the job on the next edge");
    a_cfg_stall: assert property (@(posedge clk) disable iff (!nrst)
        (busy_o && bus_valid_i && bus_addr_i >= (CSR_BASE_ADDR | 32'd1)
            && bus_addr_i <= (CSR_BASE_ADDR | 32'd5)) |-> !bus_ready_o)
        else event_error("config access accepted while busy");

    // Called at 1 ns past an edge, returns 1 ns past the accept edge
    task automatic bus_access(input logic [31:0] addr, input logic wen, input logic [31:0] wdata);
        bus_valid_i = 1'b1;
        bus_addr_i  = addr;
        bus_wen_i   = wen;
        bus_wdata_i = wdata;
        #1;
        while (!bus_ready_o) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #1;
        bus_valid_i = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] idx, input logic [31:0] data);
        bus_access(CSR_BASE_ADDR | idx, 1'b1, data);
        case (idx)
            4'd1: {cfg_sy, cfg_sx} = data[23:16];
            4'd3: {cfg_dimy, cfg_dimx} = data;
            4'd5: {cfg_offy, cfg_offx} = data;
            default: ;
        endcase
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [31:0] exp, input string name);
        bus_access(addr, 1'b0, '0);
        assert (bus_rdata_o == exp) else value_error(name, exp, bus_rdata_o);
    endtask

    // Waits out busy and the DONE cycle, then checks items and the MAIN word
    task automatic finish_job(input int n);
        while (busy_o) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        assert (items_seen == n) else value_error("window item count", n, items_seen);
        exp_count++;
        check_read(CSR_BASE_ADDR, 32'(exp_count), "bus_rdata_o (MAIN)");
    endtask

    initial begin
        nrst        = 1'b0;
        bus_valid_i = 1'b0;
        bus_addr_i  = '0;
        bus_wen_i   = 1'b0;
        bus_wdata_i = '0;
        win_ready_i = 1'b0;
        repeat (4) @(posedge clk);
        #1 nrst = 1'b1;
        assert (!busy_o && !win_valid_o) else event_error("busy_o or win_valid_o high after reset");
        for (int i = 0; i < 6; i++) begin
            check_read(CSR_BASE_ADDR | i, '0, "bus_rdata_o after reset");
        end

        // Register readback plus unmapped and outside-window accesses
        write_reg(4'd1, 32'h5A32_0C41);
        write_reg(4'd2, 32'h0010_0014);
        write_reg(4'd3, 32'h0004_0006); // 6 x 4 outputs
        write_reg(4'd4, 32'h0040_0020);
        write_reg(4'd5, 32'h0001_0005);
        check_read(CSR_BASE_ADDR | 32'd1, 32'h5A32_0C41, "bus_rdata_o (CONFIG)");
        check_read(CSR_BASE_ADDR | 32'd2, 32'h0010_0014, "bus_rdata_o (IFMAP_DIMS)");
        check_read(CSR_BASE_ADDR | 32'd3, 32'h0004_0006, "bus_rdata_o (OFMAP_DIMS)");
        check_read(CSR_BASE_ADDR | 32'd5, 32'h0001_0005, "bus_rdata_o (OFFSETS)");
        check_read(CSR_BASE_ADDR | 32'd6, '0, "bus_rdata_o (index 6)");
        check_read(CSR_BASE_ADDR | 32'd15, '0, "bus_rdata_o (index 15)");
        bus_access(32'h0000_0024, 1'b1, 32'hDEAD_BEEF);
        check_read(CSR_BASE_ADDR | 32'd4, 32'h0040_0020, "bus_rdata_o (CHANNELS)");
        check_read(32'h0000_0024, '0, "bus_rdata_o (outside window)");

        // First job
        write_reg(4'd0, 32'h1);
        finish_job(24);

        // Second job with a repeated RUN and a config write that must wait
        write_reg(4'd3, 32'h0006_0008);
        write_reg(4'd5, 32'h0002_0003);
        write_reg(4'd0, 32'h1);
        write_reg(4'd0, 32'h1);
        write_reg(4'd1, 32'h5A13_0C41);
        finish_job(48);
        check_read(CSR_BASE_ADDR | 32'd1, 32'h5A13_0C41, "bus_rdata_o (CONFIG)");

        // Clear mid-job together with RUN leaves the count unchanged
        write_reg(4'd3, 32'h0003_0005);
        write_reg(4'd0, 32'h1);
        while (items_seen < 4) begin
            @(posedge clk);
            #1;
        end
        write_reg(4'd0, 32'h9);
        @(posedge clk);
        #1;
        check_read(CSR_BASE_ADDR, 32'(exp_count), "bus_rdata_o (MAIN after clear)");
        write_reg(4'd0, 32'h9); // Clear beats RUN from idle too

        // Zero-size job
        write_reg(4'd3, 32'h0003_0000);
        write_reg(4'd0, 32'h1);
        finish_job(0);

        $display("Errors: %0d value, %0d event, %0d total",
            value_errors, event_errors, value_errors + event_errors);
        if (value_errors + event_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
